//--- vlog.f
source/mem_ctrl_pkg.sv
source/mem_req_if.sv
source/req_arbiter.sv
source/byte_sequencer.sv
source/resp_assembler.sv
source/mem_ctrl_top.sv
testbench/tb_ram_model.sv
testbench/tb_mem_ctrl.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_mem_ctrl
FLIST = vlog.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test OK" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)

//--- testbench/tb_mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_ctrl import mem_ctrl_pkg::*; ();

    localparam int ADDR_W  = 12;
    localparam int N_TESTS = 40;
    localparam int LIMIT   = N_TESTS * 16 + 8;

    logic clk = 1'b0, rst_n_i;
    logic inst_req_i, redirect_i, inst_valid_o;
    logic [ADDR_W-1:0] inst_addr_i, data_addr_i, ram_addr_o;
    logic [31:0] inst_o, data_wdata_i, data_rdata_o;
    logic data_req_i, data_wr_i, data_sign_i, wreg_i, data_busy_o, data_done_o, wreg_o;
    width_e data_width_i;
    logic [4:0] rd_tag_i, rd_tag_o;
    logic [7:0] ram_dout_o, ram_din_i;
    logic ram_wr_o;

    logic [7:0] shadow [0:(1<<ADDR_W)-1];
    logic [31:0] seed;
    int cycles = 0;
    int valid_cnt = 0;

    mem_ctrl_top #(.ADDR_W(ADDR_W)) uut (.*);

    tb_ram_model #(.ADDR_W(ADDR_W)) u_ram (
        .clk(clk), .addr_i(ram_addr_o), .din_i(ram_dout_o), .wr_i(ram_wr_o), .dout_o(ram_din_i)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (rst_n_i && inst_valid_o) valid_cnt++;
        if (cycles > LIMIT) stop_fail("timeout, the DUT stopped answering requests");
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // expected read value straight from the shadow bytes
    function automatic logic [31:0] exp_read(input logic [ADDR_W-1:0] a, input int nb,
                                             input logic sgn);
        logic [31:0] v;
        v = 32'h0;
        for (int i = 0; i < nb; i++) v[8*i +: 8] = shadow[(int'(a) + i) % (1<<ADDR_W)];
        if (nb == 1 && sgn && v[7]) v = v | 32'hffff_ff00;
        if (nb == 2 && sgn && v[15]) v = v | 32'hffff_0000;
        return v;
    endfunction

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_fail($sformatf("error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic do_fetch(input logic [ADDR_W-1:0] a);
        @(posedge clk);
        #1;
        inst_addr_i = a;
        inst_req_i  = 1'b1;
        do begin
            @(posedge clk);
            #1;
            check("data_done_o", {31'b0, data_done_o}, 32'h0);
        end while (!inst_valid_o);
        inst_req_i = 1'b0;
        check("inst_o", inst_o, exp_read(a, 4, 1'b0));
    endtask

    task automatic do_data(input logic wr, input int nb, input logic [ADDR_W-1:0] a,
                           input logic [31:0] wd, input logic sgn, input logic [4:0] tag);
        @(posedge clk);
        #1;
        data_wr_i    = wr;
        data_width_i = (nb == 1) ? W_BYTE : (nb == 2) ? W_HALF : W_WORD;
        data_addr_i  = a;
        data_wdata_i = wd;
        data_sign_i  = sgn;
        rd_tag_i     = tag;
        wreg_i       = tag[0];
        data_req_i   = 1'b1;
        do begin
            @(posedge clk);
            #1;
            check("inst_valid_o", {31'b0, inst_valid_o}, 32'h0);
        end while (!data_done_o);
        data_req_i = 1'b0;
        if (wr) begin
            for (int i = 0; i < nb; i++) shadow[(int'(a) + i) % (1<<ADDR_W)] = wd[8*i +: 8];
        end else begin
            check("data_rdata_o", data_rdata_o, exp_read(a, nb, sgn));
            check("rd_tag_o", {27'b0, rd_tag_o}, {27'b0, tag});
            check("wreg_o", {31'b0, wreg_o}, {31'b0, tag[0]});
        end
    endtask

    initial begin
        logic [31:0] r;
        int cnt0;
        bit data_seen;
        rst_n_i = 1'b0;
        {inst_req_i, redirect_i, data_req_i, data_wr_i, data_sign_i, wreg_i} = '0;
        inst_addr_i = '0;
        data_addr_i = '0;
        data_wdata_i = '0;
        data_width_i = W_WORD;
        rd_tag_i = '0;
        seed = 32'h8c8f11e6;
        for (int i = 0; i < (1<<ADDR_W); i++) begin
            r = next_rand();
            shadow[i] = r[23:16] ^ i[7:0] ^ {4'h0, i[11:8]};
            u_ram.mem[i] = shadow[i];
        end
        repeat (8) @(posedge clk);
        #1 rst_n_i = 1'b1;

        do_fetch(12'h010);
        do_fetch(12'h123);
        // stores followed by a word load over the same bytes
        do_data(1'b1, 1, 12'h200, 32'h0000_00a7, 1'b0, 5'd0);
        do_data(1'b0, 4, 12'h200, 32'h0, 1'b0, 5'd3);
        do_data(1'b1, 2, 12'h300, 32'h0000_8a55, 1'b0, 5'd0);
        do_data(1'b0, 4, 12'h300, 32'h0, 1'b0, 5'd4);
        do_data(1'b1, 4, 12'h400, 32'hdead_beef, 1'b0, 5'd0);
        do_data(1'b0, 4, 12'h400, 32'h0, 1'b0, 5'd17);
        // extension of byte and half loads
        do_data(1'b0, 1, 12'h200, 32'h0, 1'b1, 5'd9);
        do_data(1'b0, 1, 12'h200, 32'h0, 1'b0, 5'd10);
        do_data(1'b0, 2, 12'h300, 32'h0, 1'b1, 5'd21);
        do_data(1'b0, 2, 12'h300, 32'h0, 1'b0, 5'd30);

        // redirect while a fetch is in flight
        cnt0 = valid_cnt;
        @(posedge clk);
        #1;
        inst_addr_i = 12'h0a0;
        inst_req_i  = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        redirect_i  = 1'b1;
        inst_addr_i = 12'h5c4;
        @(posedge clk);
        #1 redirect_i = 1'b0;
        while (!inst_valid_o) begin
            @(posedge clk);
            #1;
        end
        inst_req_i = 1'b0;
        check("inst_o", inst_o, exp_read(12'h5c4, 4, 1'b0));
        @(posedge clk);
        #1 check("inst_valid_o count", valid_cnt - cnt0, 32'd1);

        // fetch and load raised together, the load goes first
        @(posedge clk);
        #1;
        inst_addr_i  = 12'h040;
        inst_req_i   = 1'b1;
        data_wr_i    = 1'b0;
        data_width_i = W_WORD;
        data_addr_i  = 12'h400;
        rd_tag_i     = 5'd6;
        wreg_i       = 1'b0;
        data_req_i   = 1'b1;
        data_seen    = 1'b0;
        do begin
            @(posedge clk);
            #1;
            if (!data_seen) begin
                check("data_busy_o", {31'b0, data_busy_o}, 32'h1);
                if (inst_valid_o) stop_fail("the fetch finished before the data load");
            end else begin
                check("data_busy_o", {31'b0, data_busy_o}, 32'h0);
            end
            if (data_done_o) begin
                data_req_i = 1'b0;
                data_seen  = 1'b1;
                check("data_rdata_o", data_rdata_o, exp_read(12'h400, 4, 1'b0));
            end
        end while (!inst_valid_o);
        inst_req_i = 1'b0;
        check("inst_o", inst_o, exp_read(12'h040, 4, 1'b0));

        // random mix
        for (int n = 0; n < 30; n++) begin
            r = next_rand();
            case (r[1:0])
                2'd0: do_fetch(ADDR_W'(r[31:8] % 4092));
                2'd1: do_data(1'b1, (r[3:2] == 2'd0) ? 4 : (r[3:2] == 2'd1) ? 2 : 1,
                              ADDR_W'(r[31:8] % 4092), next_rand(), 1'b0, 5'd0);
                default: do_data(1'b0, (r[3:2] == 2'd0) ? 4 : (r[3:2] == 2'd1) ? 2 : 1,
                                 ADDR_W'(r[31:8] % 4092), 32'h0, r[4], r[9:5]);
            endcase
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_ram_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ram_model #(
    parameter int ADDR_W = 12
) (
    input  wire logic              clk,
    input  wire logic [ADDR_W-1:0] addr_i,
    input  wire logic [7:0]        din_i,
    input  wire logic              wr_i,
    output logic [7:0]             dout_o
);

    logic [7:0] mem [0:(1<<ADDR_W)-1]; // filled by the testbench

    // one cycle read latency, old data on a write
    always @(posedge clk) begin
        if (wr_i) begin
            mem[addr_i] <= din_i;
        end
        dout_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

//--- source/mem_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_top import mem_ctrl_pkg::*; #(
    parameter int ADDR_W = 17
) (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    // fetch port
    input  wire logic              inst_req_i,
    input  wire logic [ADDR_W-1:0] inst_addr_i,
    input  wire logic              redirect_i,
    output logic                   inst_valid_o,
    output logic [XLEN-1:0]        inst_o,
    // data port
    input  wire logic              data_req_i,
    input  wire logic              data_wr_i,
    input  wire width_e            data_width_i,
    input  wire logic [ADDR_W-1:0] data_addr_i,
    input  wire logic [XLEN-1:0]   data_wdata_i,
    input  wire logic              data_sign_i,
    input  wire logic [4:0]        rd_tag_i,
    input  wire logic              wreg_i,
    output logic                   data_busy_o,
    output logic                   data_done_o,
    output logic [XLEN-1:0]        data_rdata_o,
    output logic [4:0]             rd_tag_o,
    output logic                   wreg_o,
    // byte RAM
    output logic [ADDR_W-1:0]      ram_addr_o,
    output logic [7:0]             ram_dout_o,
    output logic                   ram_wr_o,
    input  wire logic [7:0]        ram_din_i
);

    logic done_w;

    mem_req_if #(.ADDR_W(ADDR_W)) req_if ();

    assign done_w = inst_valid_o | data_done_o; // frees the arbiter

    req_arbiter #(.ADDR_W(ADDR_W)) u_arbiter (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_req_i   (inst_req_i),
        .inst_addr_i  (inst_addr_i),
        .redirect_i   (redirect_i),
        .data_req_i   (data_req_i),
        .data_wr_i    (data_wr_i),
        .data_width_i (data_width_i),
        .data_addr_i  (data_addr_i),
        .data_wdata_i (data_wdata_i),
        .data_sign_i  (data_sign_i),
        .rd_tag_i     (rd_tag_i),
        .wreg_i       (wreg_i),
        .done_i       (done_w),
        .data_busy_o  (data_busy_o),
        .req_if       (req_if.arb)
    );

    byte_sequencer #(.ADDR_W(ADDR_W)) u_sequencer (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .req_if     (req_if.seq),
        .ram_addr_o (ram_addr_o),
        .ram_dout_o (ram_dout_o),
        .ram_wr_o   (ram_wr_o),
        .ram_din_i  (ram_din_i)
    );

    resp_assembler u_assembler (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_if       (req_if.resp),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .data_done_o  (data_done_o),
        .data_rdata_o (data_rdata_o),
        .rd_tag_o     (rd_tag_o),
        .wreg_o       (wreg_o)
    );

endmodule

`default_nettype wire

//--- source/resp_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module resp_assembler import mem_ctrl_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    mem_req_if.resp          req_if,
    output logic             inst_valid_o,
    output logic [XLEN-1:0]  inst_o,
    output logic             data_done_o,
    output logic [XLEN-1:0]  data_rdata_o,
    output logic [4:0]       rd_tag_o,
    output logic             wreg_o
);

    logic [XLEN-1:0] ext_w;
    logic            is_fetch;
    logic            is_load;

    assign is_fetch = (req_if.kind == KIND_FETCH);
    assign is_load  = (req_if.kind == KIND_LOAD);

    // bytes above the access width are junk from the sequencer
    always_comb begin
        case (req_if.width)
            W_BYTE: begin
                ext_w = {{(XLEN-8){req_if.sign & req_if.rdata[7]}}, req_if.rdata[7:0]};
            end
            W_HALF: begin
                ext_w = {{(XLEN-16){req_if.sign & req_if.rdata[15]}}, req_if.rdata[15:0]};
            end
            default: ext_w = req_if.rdata;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;
            data_done_o  <= 1'b0;
        end else begin
            inst_valid_o <= req_if.seq_done && is_fetch;
            data_done_o  <= req_if.seq_done && !is_fetch; // stores finish here too
        end
    end

    always_ff @(posedge clk) begin
        if (req_if.seq_done && is_fetch) begin
            inst_o <= req_if.rdata;
        end
        if (req_if.seq_done && is_load) begin
            data_rdata_o <= ext_w;
        end
        if (req_if.seq_done && !is_fetch) begin
            rd_tag_o <= req_if.rd_tag;
            wreg_o   <= req_if.wreg;
        end
    end

    // one access at a time, so completions never come back to back
    a_one_done: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (inst_valid_o || data_done_o) |=> !(inst_valid_o || data_done_o)
    );

endmodule

`default_nettype wire

//--- source/byte_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module byte_sequencer import mem_ctrl_pkg::*; #(
    parameter int ADDR_W = 17
) (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    mem_req_if.seq                 req_if,
    output logic [ADDR_W-1:0]      ram_addr_o,
    output logic [7:0]             ram_dout_o,
    output logic                   ram_wr_o,
    input  wire logic [7:0]        ram_din_i
);

    seq_state_e      state_q;
    logic [1:0]      cnt_q;     // index of the byte address on the RAM
    logic [1:0]      next_idx;
    logic [1:0]      last_idx;
    logic [4:0]      shamt;
    logic            is_store;
    logic            last_addr;
    logic [XLEN-1:0] shift_q;
    logic [XLEN-1:0] word_w;

    assign is_store  = (req_if.kind == KIND_STORE);
    assign next_idx  = cnt_q + 2'd1;
    assign last_addr = (state_q == S_ADDR) && (cnt_q == last_idx);

    always_comb begin
        case (req_if.width)
            W_BYTE: begin
                last_idx = 2'd0;
                shamt    = 5'd24;
            end
            W_HALF: begin
                last_idx = 2'd1;
                shamt    = 5'd16;
            end
            default: begin
                last_idx = 2'd3;
                shamt    = 5'd0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= S_IDLE;
            cnt_q    <= 2'd0;
            ram_wr_o <= 1'b0;
        end else if (req_if.cancel) begin
            state_q  <= S_IDLE;
            cnt_q    <= 2'd0;
            ram_wr_o <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_if.start) begin
                        state_q  <= S_ADDR;
                        cnt_q    <= 2'd0;
                        ram_wr_o <= is_store;
                    end
                end
                S_ADDR: begin
                    if (cnt_q == last_idx) begin
                        state_q  <= is_store ? S_IDLE : S_DRAIN;
                        cnt_q    <= 2'd0;
                        ram_wr_o <= 1'b0;
                    end else begin
                        cnt_q <= next_idx;
                    end
                end
                S_DRAIN: state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_if.start) begin
            ram_addr_o <= req_if.addr;
            ram_dout_o <= req_if.wdata[7:0];
        end else if (state_q == S_ADDR && cnt_q != last_idx) begin
            ram_addr_o <= req_if.addr + ADDR_W'(next_idx);
            ram_dout_o <= req_if.wdata[{next_idx, 3'b000} +: 8];
        end
        // din lags the address by one cycle
        if (state_q == S_ADDR && cnt_q != 2'd0 && !is_store) begin
            shift_q <= {ram_din_i, shift_q[XLEN-1:8]};
        end
    end

    // last byte joins straight from the RAM in the drain cycle
    assign word_w = {ram_din_i, shift_q[XLEN-1:8]};
    assign req_if.rdata = word_w >> shamt;

    assign req_if.seq_done = ((last_addr && is_store) || state_q == S_DRAIN) && !req_if.cancel;

    a_wr_only_store: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ram_wr_o |-> req_if.kind == KIND_STORE
    );

    a_cancel_only_fetch: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        req_if.cancel |-> req_if.kind == KIND_FETCH
    );

endmodule

`default_nettype wire

//--- source/req_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module req_arbiter import mem_ctrl_pkg::*; #(
    parameter int ADDR_W = 17
) (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              inst_req_i,
    input  wire logic [ADDR_W-1:0] inst_addr_i,
    input  wire logic              redirect_i,
    input  wire logic              data_req_i,
    input  wire logic              data_wr_i,
    input  wire width_e            data_width_i,
    input  wire logic [ADDR_W-1:0] data_addr_i,
    input  wire logic [XLEN-1:0]   data_wdata_i,
    input  wire logic              data_sign_i,
    input  wire logic [4:0]        rd_tag_i,
    input  wire logic              wreg_i,
    input  wire logic              done_i,
    output logic                   data_busy_o,
    mem_req_if.arb                 req_if
);

    logic busy_q;
    logic grant;

    // busy covers the start cycle, so the sequencer is idle whenever busy_q is low
    assign grant = !busy_q && (data_req_i || inst_req_i);

    // a redirect only kills a fetch, data accesses run to the end
    assign req_if.cancel = redirect_i && busy_q && (req_if.kind == KIND_FETCH);

    assign data_busy_o = busy_q && (req_if.kind != KIND_FETCH);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q       <= 1'b0;
            req_if.start <= 1'b0;
        end else begin
            req_if.start <= grant;
            if (grant) begin
                busy_q <= 1'b1;
            end else if (done_i || req_if.cancel) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant && data_req_i) begin // data first
            req_if.kind   <= data_wr_i ? KIND_STORE : KIND_LOAD;
            req_if.width  <= data_width_i;
            req_if.addr   <= data_addr_i;
            req_if.wdata  <= data_wdata_i;
            req_if.sign   <= data_sign_i;
            req_if.rd_tag <= rd_tag_i;
            req_if.wreg   <= wreg_i;
        end else if (grant) begin
            req_if.kind  <= KIND_FETCH;
            req_if.width <= W_WORD; // instructions are always 4 bytes
            req_if.addr  <= inst_addr_i;
            req_if.sign  <= 1'b0;
        end
    end

    // busy only drops on a real completion, so no start can overlap an access
    a_start_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        done_i |-> busy_q && !req_if.start
    );

endmodule

`default_nettype wire

//--- source/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import mem_ctrl_pkg::*; #(
    parameter int ADDR_W = 17
) ();

    logic              start;    // one cycle per grant
    req_kind_e         kind;
    width_e            width;
    logic [ADDR_W-1:0] addr;     // base byte address
    logic [XLEN-1:0]   wdata;
    logic              sign;
    logic [4:0]        rd_tag;
    logic              wreg;
    logic              cancel;   // fetch dropped by redirect
    logic [XLEN-1:0]   rdata;    // read bytes, right aligned
    logic              seq_done;

    modport arb (
        output start, kind, width, addr, wdata, sign, rd_tag, wreg, cancel
    );

    modport seq (
        input  start, kind, width, addr, wdata, cancel,
        output rdata, seq_done
    );

    modport resp (
        input kind, width, sign, rd_tag, wreg, rdata, seq_done
    );

endinterface

`default_nettype wire

//--- source/mem_ctrl_pkg.sv
`default_nettype none

package mem_ctrl_pkg;

    parameter int XLEN = 32;

    // who owns the access in flight
    typedef enum logic [1:0] {
        KIND_FETCH = 2'd0,
        KIND_LOAD  = 2'd1,
        KIND_STORE = 2'd2
    } req_kind_e;

    // same codes as the old access size field
    typedef enum logic [1:0] {
        W_BYTE = 2'b01,
        W_HALF = 2'b10,
        W_WORD = 2'b11
    } width_e;

    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_ADDR  = 2'd1, // one byte address per cycle
        S_DRAIN = 2'd2  // last read byte on ram_din_i
    } seq_state_e;

endpackage

`default_nettype wire
